/* build.f */
rtl/pcie_tx_pkg.sv
rtl/tx_sequencer.sv
rtl/completion_tlp_builder.sv
rtl/read_request_tlp_builder.sv
rtl/write_request_tlp_builder.sv
rtl/tx_stream_output.sv
rtl/pcie_tx.sv
testbench/pcie_tx_chk.sv
testbench/pcie_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module pcie_tx_tb -o pcie_tx_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi
out=$(./obj_dir/pcie_tx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
if echo "$out" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1

/* testbench/pcie_tx_tb.sv */
`timescale 1ns/1ps

module pcie_tx_tb;
   import pcie_tx_pkg::*;

   localparam int write_beats = 16;
   localparam int read_request_dw = 128;
   localparam int reset_cycles = 10;
   localparam int packets_per_test = 10;
   localparam int planned_packets = 5 * packets_per_test;
   localparam int cycle_limit = 40 * planned_packets + reset_cycles;

   logic clock;
   logic reset;
   requester_id_t pcie_id;
   logic read_completion_valid;
   rid_tag_t read_completion_rid_tag;
   lower_addr_t read_completion_lower_addr;
   data_word_t read_completion_data;
   logic read_completion_ready;
   logic read_request_valid;
   pcie_addr_t read_request_address;
   tlp_tag_t read_request_tag;
   logic read_request_ready;
   logic write_request_valid;
   pcie_addr_t write_request_address;
   data_word_t write_request_data;
   logic write_request_ready;
   logic axis_tx_tready;
   tlp_beat_t axis_tx_tdata;
   logic axis_tx_tvalid;
   logic axis_tx_tlast;
   logic axis_tx_1dw;

   int errors = 0;
   int cycle_count = 0;
   int packets_done = 0;
   int write_pulses = 0;
   logic busy = 1'b0;  // model of the sequencer leaving idle
   logic en_cpl = 1'b0;
   logic en_rd = 1'b0;
   logic en_wr = 1'b0;
   logic stall_enable = 1'b0;

   tx_kind_t order_q[$];  // kinds in the order the arbiter should pick them
   rid_tag_t cpl_rid_q[$];
   lower_addr_t cpl_la_q[$];
   data_word_t cpl_data_q[$];
   pcie_addr_t rd_addr_q[$];
   tlp_tag_t rd_tag_q[$];
   pcie_addr_t wr_addr_q[$];
   data_word_t wr_words[$];
   data_word_t cur_words[$];
   tlp_beat_t beats[$];
   logic [1:0] flags[$];  // tlast, tx_1dw

   tlp_beat_t p_tdata;
   logic p_tvalid = 1'b0;
   logic p_tready = 1'b0;
   logic p_tlast = 1'b0;
   logic p_1dw = 1'b0;
   logic p_cv = 1'b0;
   logic p_rv = 1'b0;
   logic p_wv = 1'b0;
   logic p_cr = 1'b0;
   logic p_rr = 1'b0;

   pcie_tx #(.write_beats(write_beats), .read_request_dw(read_request_dw)) pcie_tx_i (.*);

   initial
   begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   always @(posedge clock)
      cycle_count <= cycle_count + 1;

   initial
   begin
      wait (cycle_count >= cycle_limit);
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
   end

   // byte i of the result is byte 3-i of the input
   function automatic tlp_dw_t swap_bytes(input tlp_dw_t dw);
      tlp_dw_t r;
      for (int i = 0; i < 4; i++)
         r[8*i +: 8] = dw[8*(3-i) +: 8];
      return r;
   endfunction

   task automatic new_completion(input logic on);
      read_completion_valid = on;
      read_completion_rid_tag = rid_tag_t'($urandom);
      read_completion_lower_addr = lower_addr_t'($urandom);
      read_completion_data = {$urandom, $urandom};
   endtask

   task automatic new_read(input logic on);
      read_request_valid = on;
      read_request_address = {$urandom, $urandom};
      read_request_tag = tlp_tag_t'($urandom);
   endtask

   // data is left alone, the last word of a packet may still be needed
   task automatic new_write(input logic on);
      write_request_valid = on;
      write_request_address = {$urandom, $urandom};
   endtask

   task automatic fail_value(input string what, input tlp_beat_t got, input tlp_beat_t exp);
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
   endtask

   // compares the collected beats with the packet the model expects
   task automatic check_packet();
      tx_kind_t kind;
      tlp_beat_t exp[$];
      data_word_t d;
      pcie_addr_t a;
      logic [1:0] ef;
      int n;
      if (order_q.size() == 0)
      begin
         $display("Error: a packet arrived that no request was arbitrated for");
         errors++;
      end
      else
      begin
         kind = order_q.pop_front();
         if (kind == kind_completion && cpl_data_q.size() > 0)
         begin
            d = cpl_data_q.pop_front();
            exp.push_back({pcie_id, 16'd8, 32'h4A00_0002});
            exp.push_back({swap_bytes(d[31:0]), cpl_rid_q.pop_front(), 1'b0,
                           cpl_la_q.pop_front(), 3'b000});
            exp.push_back({32'h0, swap_bytes(d[63:32])});
         end
         else if (kind == kind_read && rd_addr_q.size() > 0)
         begin
            a = rd_addr_q.pop_front();
            exp.push_back({pcie_id, rd_tag_q.pop_front(), 8'hFF, 8'h20, 24'(read_request_dw)});
            exp.push_back({a[31:0], a[63:32]});
         end
         else if (kind == kind_write && wr_addr_q.size() > 0)
         begin
            a = wr_addr_q.pop_front();
            exp.push_back({pcie_id, 8'h00, 8'hFF, 8'h60, 24'(2 * write_beats)});
            exp.push_back({a[31:0], a[63:32]});
            for (int i = 0; i < write_beats; i++)
            begin
               d = wr_words.pop_front();
               exp.push_back({swap_bytes(d[63:32]), swap_bytes(d[31:0])});
            end
         end
         n = exp.size();
         if (n == 0)
         begin
            $display("Error: packet of kind %s ended before its ready pulses", kind.name());
            errors++;
         end
         else if (beats.size() != n)
            fail_value("beat count", tlp_beat_t'(beats.size()), tlp_beat_t'(n));
         else
         begin
            for (int i = 0; i < n; i++)
            begin
               ef = {i == n - 1, kind == kind_completion && i == 2};
               if (beats[i] != exp[i])
                  fail_value($sformatf("%s beat %0d data", kind.name(), i), beats[i], exp[i]);
               if (flags[i] != ef)
                  fail_value($sformatf("%s beat %0d tlast/1dw", kind.name(), i),
                             tlp_beat_t'(flags[i]), tlp_beat_t'(ef));
            end
         end
      end
      packets_done++;
      beats.delete();
      flags.delete();
   endtask

   // one clock: observe the edge, update the model, drive new inputs
   task automatic step();
      data_word_t w;
      @(posedge clock);
      #2;
      if (p_tvalid && p_tready)
      begin
         beats.push_back(p_tdata);
         flags.push_back({p_tlast, p_1dw});
         if (p_tlast)
            check_packet();
      end
      if (!busy)
      begin
         if (p_cv && !p_cr)
            order_q.push_back(kind_completion);
         else if (p_rv && !p_rr)
            order_q.push_back(kind_read);
         else if (p_wv)
            order_q.push_back(kind_write);
         busy = (p_cv && !p_cr) || (p_rv && !p_rr) || p_wv;
      end
      else if ((p_tready || !p_tvalid) && axis_tx_tvalid && axis_tx_tlast)
         busy = 1'b0;  // last beat loaded, idle again

      if (read_completion_ready)
      begin
         cpl_rid_q.push_back(read_completion_rid_tag);
         cpl_la_q.push_back(read_completion_lower_addr);
         cpl_data_q.push_back(read_completion_data);
         new_completion(en_cpl && $urandom % 2 == 0);
      end
      if (read_request_ready)
      begin
         rd_addr_q.push_back(read_request_address);
         rd_tag_q.push_back(read_request_tag);
         new_read(en_rd && $urandom % 2 == 0);
      end
      if (write_request_ready)
      begin
         w = {$urandom, $urandom};
         write_request_data = w;
         cur_words.push_back(w);
         write_pulses++;
         if (write_pulses == write_beats)
         begin
            wr_addr_q.push_back(write_request_address);
            foreach (cur_words[i])
               wr_words.push_back(cur_words[i]);
            cur_words.delete();
            write_pulses = 0;
            new_write(en_wr && $urandom % 2 == 0);
         end
      end

      if (!read_completion_valid && en_cpl && $urandom % 4 == 0)
         new_completion(1'b1);
      if (!read_request_valid && en_rd && $urandom % 4 == 0)
         new_read(1'b1);
      if (!write_request_valid && en_wr && $urandom % 4 == 0)
         new_write(1'b1);
      axis_tx_tready = stall_enable ? ($urandom % 3 != 0) : 1'b1;

      p_tdata = axis_tx_tdata;
      p_tvalid = axis_tx_tvalid;
      p_tlast = axis_tx_tlast;
      p_1dw = axis_tx_1dw;
      p_tready = axis_tx_tready;
      p_cv = read_completion_valid;
      p_rv = read_request_valid;
      p_wv = write_request_valid;
      p_cr = read_completion_ready;
      p_rr = read_request_ready;
   endtask

   task automatic run_test(input int number, input string name, input logic c, input logic r,
                           input logic wr, input logic stall);
      int start_packets;
      int start_errors;
      start_packets = packets_done;
      start_errors = errors;
      en_cpl = c;
      en_rd = r;
      en_wr = wr;
      stall_enable = stall;
      while (packets_done < start_packets + packets_per_test)
         step();
      en_cpl = 1'b0;
      en_rd = 1'b0;
      en_wr = 1'b0;
      // drain whatever is still pending
      while (read_completion_valid || read_request_valid || write_request_valid || busy
             || order_q.size() != 0 || axis_tx_tvalid || write_pulses != 0)
         step();
      if (cpl_data_q.size() != 0 || rd_addr_q.size() != 0 || wr_addr_q.size() != 0)
      begin
         $display("Error: test %0d saw a ready pulse with no matching packet", number);
         errors++;
      end
      $display("test %0d %s: %0d packets, %0d errors", number, name,
               packets_done - start_packets, errors - start_errors);
   endtask

   initial
   begin
      int assert_failures;
      pcie_id = requester_id_t'($urandom(32'h933e172c));  // seeds $urandom once
      reset = 1'b1;
      new_completion(1'b0);
      new_read(1'b0);
      new_write(1'b0);
      write_request_data = '0;
      axis_tx_tready = 1'b0;
      repeat (reset_cycles) @(posedge clock);
      #2;
      reset = 1'b0;

      for (int i = 0; i < reset_cycles; i++)
      begin
         step();
         if (axis_tx_tvalid || axis_tx_tlast || axis_tx_1dw || read_completion_ready
             || read_request_ready || write_request_ready)
            fail_value("output high after reset", tlp_beat_t'(1), tlp_beat_t'(0));
      end
      $display("test 1 reset: %0d errors", errors);

      run_test(2, "completions", 1'b1, 1'b0, 1'b0, 1'b1);
      run_test(3, "read requests", 1'b0, 1'b1, 1'b0, 1'b1);
      run_test(4, "write requests", 1'b0, 1'b0, 1'b1, 1'b1);
      run_test(5, "priority", 1'b1, 1'b1, 1'b1, 1'b0);
      run_test(6, "back-pressure", 1'b1, 1'b1, 1'b1, 1'b1);

      assert_failures = pcie_tx_i.chk_i.failures;
      $display("%0d packets, %0d check errors, %0d assertion failures",
               packets_done, errors, assert_failures);
      if (errors == 0 && assert_failures == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* testbench/pcie_tx_chk.sv */
`timescale 1ns/1ps

module pcie_tx_chk
(
   input logic                   clock,
   input logic                   reset,
   input logic                   axis_tx_tready,
   input logic                   axis_tx_tvalid,
   input logic                   axis_tx_tlast,
   input logic                   axis_tx_1dw,
   input pcie_tx_pkg::tlp_beat_t axis_tx_tdata,
   input logic                   read_completion_ready,
   input logic                   read_request_ready,
   input logic                   write_request_ready
);
   import pcie_tx_pkg::*;

   int failures = 0;  // read by the testbench at the end

   // a stalled beat must wait unchanged
   hold_while_stalled: assert property (@(posedge clock) disable iff (reset)
      axis_tx_tvalid && !axis_tx_tready |=>
         $stable(axis_tx_tdata) && $stable(axis_tx_tlast) && $stable(axis_tx_1dw))
   else
   begin
      $error("stream beat changed while the core stalled");
      failures++;
   end

   one_dw_is_last: assert property (@(posedge clock) disable iff (reset)
      axis_tx_1dw |-> axis_tx_tlast)
   else
   begin
      $error("tx_1dw set on a beat that is not the last");
      failures++;
   end

   ready_pulses_apart: assert property (@(posedge clock) disable iff (reset)
      $onehot0({read_completion_ready, read_request_ready, write_request_ready}))
   else
   begin
      $error("two ready outputs high in the same cycle");
      failures++;
   end

endmodule

bind pcie_tx pcie_tx_chk chk_i (.*);

/* rtl/pcie_tx.sv */
`timescale 1ns/1ps

module pcie_tx
#(
   parameter int write_beats = 16,
   parameter int read_request_dw = 128
)
(
   input  logic                       clock,
   input  logic                       reset,
   input  pcie_tx_pkg::requester_id_t pcie_id,
   // read completion
   input  logic                       read_completion_valid,
   input  pcie_tx_pkg::rid_tag_t      read_completion_rid_tag,
   input  pcie_tx_pkg::lower_addr_t   read_completion_lower_addr,
   input  pcie_tx_pkg::data_word_t    read_completion_data,
   output logic                       read_completion_ready,
   // read request
   input  logic                       read_request_valid,
   input  pcie_tx_pkg::pcie_addr_t    read_request_address,
   input  pcie_tx_pkg::tlp_tag_t      read_request_tag,
   output logic                       read_request_ready,
   // write request
   input  logic                       write_request_valid,
   input  pcie_tx_pkg::pcie_addr_t    write_request_address,
   input  pcie_tx_pkg::data_word_t    write_request_data,
   output logic                       write_request_ready,
   // stream toward the core
   input  logic                       axis_tx_tready,
   output pcie_tx_pkg::tlp_beat_t     axis_tx_tdata,
   output logic                       axis_tx_tvalid,
   output logic                       axis_tx_tlast,
   output logic                       axis_tx_1dw
);
   import pcie_tx_pkg::*;

   tx_slot_t slot;
   tlp_beat_t completion_beat;
   tlp_beat_t read_beat;
   tlp_beat_t write_beat;

   tx_sequencer #(.write_beats(write_beats)) tx_sequencer_i
   (
      .clock(clock),
      .reset(reset),
      .read_completion_valid(read_completion_valid),
      .read_request_valid(read_request_valid),
      .write_request_valid(write_request_valid),
      .axis_tx_tready(axis_tx_tready),
      .tvalid_out(axis_tx_tvalid),
      .slot(slot),
      .read_completion_ready(read_completion_ready),
      .read_request_ready(read_request_ready),
      .write_request_ready(write_request_ready)
   );

   completion_tlp_builder completion_tlp_builder_i
   (
      .slot(slot),
      .pcie_id(pcie_id),
      .rid_tag(read_completion_rid_tag),
      .lower_addr(read_completion_lower_addr),
      .data(read_completion_data),
      .beat(completion_beat)
   );

   read_request_tlp_builder #(.read_request_dw(read_request_dw)) read_request_tlp_builder_i
   (
      .slot(slot),
      .pcie_id(pcie_id),
      .address(read_request_address),
      .tag(read_request_tag),
      .beat(read_beat)
   );

   write_request_tlp_builder #(.write_beats(write_beats)) write_request_tlp_builder_i
   (
      .slot(slot),
      .pcie_id(pcie_id),
      .address(write_request_address),
      .data(write_request_data),
      .beat(write_beat)
   );

   tx_stream_output tx_stream_output_i
   (
      .clock(clock),
      .reset(reset),
      .slot(slot),
      .axis_tx_tready(axis_tx_tready),
      .completion_beat(completion_beat),
      .read_beat(read_beat),
      .write_beat(write_beat),
      .axis_tx_tdata(axis_tx_tdata),
      .axis_tx_tvalid(axis_tx_tvalid),
      .axis_tx_tlast(axis_tx_tlast),
      .axis_tx_1dw(axis_tx_1dw)
   );

endmodule

/* rtl/tx_stream_output.sv */
`timescale 1ns/1ps

module tx_stream_output
(
   input  logic                   clock,
   input  logic                   reset,
   input  pcie_tx_pkg::tx_slot_t  slot,
   input  logic                   axis_tx_tready,
   input  pcie_tx_pkg::tlp_beat_t completion_beat,
   input  pcie_tx_pkg::tlp_beat_t read_beat,
   input  pcie_tx_pkg::tlp_beat_t write_beat,
   output pcie_tx_pkg::tlp_beat_t axis_tx_tdata,
   output logic                   axis_tx_tvalid,
   output logic                   axis_tx_tlast,
   output logic                   axis_tx_1dw
);
   import pcie_tx_pkg::*;

   tlp_beat_t beat_sel;
   logic load;

   assign load = axis_tx_tready | ~axis_tx_tvalid;  // hold while the core stalls

   always_comb
   begin
      case (slot.kind)
         kind_completion: beat_sel = completion_beat;
         kind_read:       beat_sel = read_beat;
         kind_write:      beat_sel = write_beat;
         default:         beat_sel = '0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         axis_tx_tdata <= '0;
         axis_tx_tvalid <= 1'b0;
         axis_tx_tlast <= 1'b0;
         axis_tx_1dw <= 1'b0;
      end
      else if (load)
      begin
         axis_tx_tdata <= beat_sel;
         axis_tx_tvalid <= (slot.kind != kind_idle);
         axis_tx_tlast <= slot.last;
         axis_tx_1dw <= slot.one_dw;
      end
   end

endmodule

/* rtl/write_request_tlp_builder.sv */
`timescale 1ns/1ps

module write_request_tlp_builder
#(
   parameter int write_beats = 16
)
(
   input  pcie_tx_pkg::tx_slot_t      slot,
   input  pcie_tx_pkg::requester_id_t pcie_id,
   input  pcie_tx_pkg::pcie_addr_t    address,
   input  pcie_tx_pkg::data_word_t    data,
   output pcie_tx_pkg::tlp_beat_t     beat
);
   import pcie_tx_pkg::*;

   tlp_dw_t header_dw0;
   tlp_dw_t header_dw1;
   tlp_beat_t data_beat;

   // two DW per data beat
   assign header_dw0 = {mwr_fmt_type, 24'(2 * write_beats)};
   assign header_dw1 = {pcie_id, 8'h00, 8'hFF};

   // each DW swapped in place, low DW still goes first
   assign data_beat = {byte_swap_dw(data[63:32]), byte_swap_dw(data[31:0])};

   always_comb
   begin
      case (slot.beat)
         5'd0:    beat = {header_dw1, header_dw0};
         5'd1:    beat = {address[31:0], address[63:32]};
         default: beat = data_beat;
      endcase
   end

endmodule

/* rtl/read_request_tlp_builder.sv */
`timescale 1ns/1ps

module read_request_tlp_builder
#(
   parameter int read_request_dw = 128
)
(
   input  pcie_tx_pkg::tx_slot_t      slot,
   input  pcie_tx_pkg::requester_id_t pcie_id,
   input  pcie_tx_pkg::pcie_addr_t    address,
   input  pcie_tx_pkg::tlp_tag_t      tag,
   output pcie_tx_pkg::tlp_beat_t     beat
);
   import pcie_tx_pkg::*;

   tlp_dw_t header_dw0;
   tlp_dw_t header_dw1;

   assign header_dw0 = {mrd_fmt_type, 24'(read_request_dw)};
   assign header_dw1 = {pcie_id, tag, 8'hFF};  // all bytes enabled

   always_comb
   begin
      case (slot.beat)
         5'd0:    beat = {header_dw1, header_dw0};
         5'd1:    beat = {address[31:0], address[63:32]};  // high DW first
         default: beat = '0;
      endcase
   end

endmodule

/* rtl/completion_tlp_builder.sv */
`timescale 1ns/1ps

module completion_tlp_builder
(
   input  pcie_tx_pkg::tx_slot_t      slot,
   input  pcie_tx_pkg::requester_id_t pcie_id,
   input  pcie_tx_pkg::rid_tag_t      rid_tag,
   input  pcie_tx_pkg::lower_addr_t   lower_addr,
   input  pcie_tx_pkg::data_word_t    data,
   output pcie_tx_pkg::tlp_beat_t     beat
);
   import pcie_tx_pkg::*;

   tlp_dw_t completer_dw;
   tlp_dw_t requester_dw;
   tlp_dw_t data_low_dw;
   tlp_dw_t data_high_dw;

   assign completer_dw = {pcie_id, 16'd8};  // byte count 8
   assign requester_dw = {rid_tag, 1'b0, lower_addr, 3'b000};
   assign data_low_dw = byte_swap_dw(data[31:0]);
   assign data_high_dw = byte_swap_dw(data[63:32]);

   always_comb
   begin
      case (slot.beat)
         5'd0:    beat = {completer_dw, cpl_header_dw0};
         5'd1:    beat = {data_low_dw, requester_dw};
         5'd2:    beat = {32'h0, data_high_dw};  // single DW beat
         default: beat = '0;
      endcase
   end

endmodule

/* rtl/tx_sequencer.sv */
`timescale 1ns/1ps

module tx_sequencer
#(
   parameter int write_beats = 16
)
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  read_completion_valid,
   input  logic                  read_request_valid,
   input  logic                  write_request_valid,
   input  logic                  axis_tx_tready,
   input  logic                  tvalid_out,
   output pcie_tx_pkg::tx_slot_t slot,
   output logic                  read_completion_ready,
   output logic                  read_request_ready,
   output logic                  write_request_ready  // once per word, one beat ahead of it
);
   import pcie_tx_pkg::*;

   localparam beat_index_t write_last_beat = beat_index_t'(write_beats + 1);
   localparam beat_index_t write_ready_last = beat_index_t'(write_beats);

   logic advance;
   logic write_word_due;
   logic write_ready_q;

   // fills in last and one_dw for a given beat
   function automatic tx_slot_t slot_for(input tx_kind_t kind, input beat_index_t beat);
      tx_slot_t s;
      s.kind = kind;
      s.beat = beat;
      s.one_dw = (kind == kind_completion) && (beat == 5'd2);
      case (kind)
         kind_completion: s.last = (beat == 5'd2);
         kind_read:       s.last = (beat == 5'd1);
         kind_write:      s.last = (beat == write_last_beat);
         default:         s.last = 1'b0;
      endcase
      return s;
   endfunction

   // output register takes a new beat when empty or when its beat goes out
   assign advance = axis_tx_tready | ~tvalid_out;

   // header beat 1 asks for the first word, data beats ask for the rest
   assign write_word_due = (slot.kind == kind_write)
                           && (slot.beat != '0)
                           && (slot.beat <= write_ready_last);

   assign write_request_ready = write_ready_q & tvalid_out;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         slot <= slot_for(kind_idle, '0);
         read_completion_ready <= 1'b0;
         read_request_ready <= 1'b0;
         write_ready_q <= 1'b0;
      end
      else
      begin
         read_completion_ready <= advance && (slot.kind == kind_completion) && slot.last;
         read_request_ready <= advance && (slot.kind == kind_read) && slot.last;
         write_ready_q <= advance && write_word_due;

         if (slot.kind == kind_idle)
         begin
            // a source still seeing its ready pulse is already served
            if (read_completion_valid && !read_completion_ready)
               slot <= slot_for(kind_completion, '0);
            else if (read_request_valid && !read_request_ready)
               slot <= slot_for(kind_read, '0);
            else if (write_request_valid)
               slot <= slot_for(kind_write, '0);
         end
         else if (advance)
         begin
            if (slot.last)
               slot <= slot_for(kind_idle, '0);
            else
               slot <= slot_for(slot.kind, slot.beat + 1'b1);
         end
      end
   end

endmodule

/* rtl/pcie_tx_pkg.sv */
package pcie_tx_pkg;

   typedef logic [15:0] requester_id_t;  // bus, device, function
   typedef logic [31:0] tlp_dw_t;
   typedef logic [63:0] tlp_beat_t;      // lower DW goes out first
   typedef logic [63:0] pcie_addr_t;
   typedef logic [63:0] data_word_t;     // host byte order
   typedef logic [23:0] rid_tag_t;       // requester id and tag of the read
   typedef logic [7:0]  tlp_tag_t;
   typedef logic [3:0]  lower_addr_t;    // address bits 6:3
   typedef logic [4:0]  beat_index_t;

   typedef enum logic [1:0]
   {
      kind_idle,
      kind_completion,
      kind_read,
      kind_write
   } tx_kind_t;

   // the beat the sequencer points at
   typedef struct packed
   {
      tx_kind_t    kind;
      beat_index_t beat;
      logic        last;
      logic        one_dw;
   } tx_slot_t;

   // completion with data, length 2 DW
   localparam tlp_dw_t cpl_header_dw0 = 32'h4A00_0002;

   // 4 DW header, 64-bit address
   localparam logic [7:0] mrd_fmt_type = 8'h20;
   localparam logic [7:0] mwr_fmt_type = 8'h60;

   // PCIe wants the first byte in the top lane
   function automatic tlp_dw_t byte_swap_dw(input tlp_dw_t dw);
      return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
   endfunction

endpackage
